//--- cce_params.svh
// Address, block, set, LCE, CCE, way and way-group size macros

`ifndef CCE_PARAMS_SVH
`define CCE_PARAMS_SVH

// Physical address and data widths
`define CCE_PADDR_WIDTH 16
`define CCE_LG_BLOCK_BYTES 3
`define CCE_BLOCK_WIDTH 64
`define CCE_NC_DATA_WIDTH 16

// LCE geometry
`define CCE_LG_SETS 4
`define CCE_LG_ASSOC 2
`define CCE_LG_NUM_LCE 2

// Two CCEs share the sets of each LCE
`define CCE_LG_NUM_CCE 1

// Pending table index and the bit just above the way-group field
`define CCE_LG_WAY_GROUPS 3
`define CCE_WG_HIGH (`CCE_LG_BLOCK_BYTES + `CCE_LG_SETS)

`endif

//--- cce_pkg.sv
// Opcode and select enums, instruction structs, memory and LCE command structs
`default_nettype none

`include "cce_params.svh"

package cce_pkg;

  typedef logic [`CCE_PADDR_WIDTH-1:0]   cce_addr_t;
  typedef logic [`CCE_BLOCK_WIDTH-1:0]   cce_block_t;
  typedef logic [`CCE_NC_DATA_WIDTH-1:0] cce_nc_data_t;
  typedef logic [`CCE_LG_SETS-1:0]       cce_set_t;
  typedef logic [`CCE_LG_NUM_LCE-1:0]    cce_lce_id_t;
  typedef logic [`CCE_LG_NUM_CCE-1:0]    cce_cce_id_t;
  typedef logic [`CCE_LG_ASSOC-1:0]      cce_way_t;
  typedef logic [`CCE_LG_WAY_GROUPS-1:0] cce_wg_t;
  // MOESI-style coherence state as sent to an LCE
  typedef logic [2:0]                    cce_coh_state_t;

  // Opcodes 2 and 3 are no-ops
  typedef enum logic [1:0] {
    e_op_mem_cmd = 2'd0,
    e_op_lce_cmd = 2'd1
  } cce_op_e;

  typedef enum logic [1:0] {
    e_lce_sel_req  = 2'd0,
    e_lce_sel_inst = 2'd1,
    e_lce_sel_zero = 2'd2
  } cce_lce_sel_e;

  typedef enum logic [1:0] {
    e_addr_sel_set = 2'd0,
    e_addr_sel_req = 2'd1,
    e_addr_sel_lru = 2'd2
  } cce_addr_sel_e;

  typedef enum logic [1:0] {
    e_way_sel_req  = 2'd0,
    e_way_sel_lru  = 2'd1,
    e_way_sel_zero = 2'd2
  } cce_way_sel_e;

  typedef enum logic [1:0] {
    e_cmd_invalidate = 2'd0,
    e_cmd_set_tag    = 2'd1,
    e_cmd_transfer   = 2'd2,
    e_cmd_writeback  = 2'd3
  } cce_lce_cmd_e;

  typedef enum logic {
    e_mem_wr = 1'b0,
    e_mem_rd = 1'b1
  } cce_mem_type_e;

  // LCE data command type, cached fill or uncached word
  typedef enum logic {
    e_data_cmd_cce = 1'b0,
    e_data_cmd_nc  = 1'b1
  } cce_data_cmd_e;

  typedef struct packed {
    cce_op_e       op;
    cce_lce_sel_e  lce_sel;
    cce_addr_sel_e addr_sel;
    cce_way_sel_e  way_sel;
    cce_lce_cmd_e  cmd;
    cce_set_t      set;
    cce_lce_id_t   lce;
  } cce_inst_s;

  typedef struct packed {
    logic          mem_cmd_v;
    logic          lce_cmd_v;
    logic          mem_addr_lru;
    cce_lce_sel_e  lce_sel;
    cce_addr_sel_e addr_sel;
    cce_way_sel_e  way_sel;
    cce_lce_cmd_e  cmd;
    cce_set_t      set;
    cce_lce_id_t   lce;
  } cce_decoded_s;

  typedef struct packed {
    cce_mem_type_e msg_type;
    cce_addr_t     addr;
    cce_lce_id_t   lce;
    cce_way_t      way;
    logic          uncached;
    cce_block_t    data;
  } cce_mem_cmd_s;

  typedef struct packed {
    cce_lce_id_t    dst;
    cce_cce_id_t    src;
    cce_lce_cmd_e   msg_type;
    cce_addr_t      addr;
    cce_way_t       way;
    cce_coh_state_t state;
    cce_lce_id_t    target;
    cce_way_t       target_way;
  } cce_lce_cmd_s;

endpackage

`default_nettype wire

//--- cce_inst_decode.sv
// Decode stage that takes an instruction word and holds its decoded form
`timescale 1ns/1ps
`default_nettype none

module cce_inst_decode
  import cce_pkg::*;
  (
    input  logic         clk_i
  , input  logic         rst_i

  , input  cce_inst_s    inst_i
  , input  logic         inst_v_i
  , output logic         inst_yumi_o

  , output logic         dec_v_o
  , output cce_decoded_s dec_o
  , input  logic         dec_done_i
  );

  logic         dec_v_q;
  cce_decoded_s dec_q;
  cce_decoded_s dec_d;

  // Take a new word when empty or when the held one retires this cycle
  assign inst_yumi_o = inst_v_i & (~dec_v_q | dec_done_i);

  always_comb begin
    dec_d     = '0;
    dec_d.cmd = inst_i.cmd;
    dec_d.set = inst_i.set;
    dec_d.lce = inst_i.lce;
    case (inst_i.op)
      e_op_mem_cmd: begin
        dec_d.mem_cmd_v    = 1'b1;
        // Writebacks go out to the victim (LRU) address
        dec_d.mem_addr_lru = (inst_i.cmd == e_cmd_writeback);
      end
      e_op_lce_cmd: begin
        dec_d.lce_cmd_v = 1'b1;
        dec_d.lce_sel   = inst_i.lce_sel;
        dec_d.addr_sel  = inst_i.addr_sel;
        dec_d.way_sel   = inst_i.way_sel;
      end
      default: begin
        // No-op, retires without sending anything
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_v_q <= 1'b0;
    end else if (inst_yumi_o) begin
      dec_v_q <= 1'b1;
    end else if (dec_done_i) begin
      dec_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (inst_yumi_o) begin
      dec_q <= dec_d;
    end
  end

  assign dec_v_o = dec_v_q;
  assign dec_o   = dec_q;

endmodule

`default_nettype wire

//--- cce_pending_bits.sv
// Pending-bit table indexed by way group, one read port and one write port
`timescale 1ns/1ps
`default_nettype none

`include "cce_params.svh"

module cce_pending_bits
  (
    input  logic                          clk_i
  , input  logic                          rst_i

  , input  logic [`CCE_LG_WAY_GROUPS-1:0] rd_wg_i
  , output logic                          rd_bit_o

  , input  logic                          w_v_i
  , input  logic [`CCE_LG_WAY_GROUPS-1:0] w_wg_i
  , input  logic                          w_bit_i
  );

  localparam int num_wg = 1 << `CCE_LG_WAY_GROUPS;

  logic [num_wg-1:0] bits_q;

  // Read sees the value from before this cycle's write
  assign rd_bit_o = bits_q[rd_wg_i];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bits_q <= '0;
    end else if (w_v_i) begin
      bits_q[w_wg_i] <= w_bit_i;
    end
  end

endmodule

`default_nettype wire

//--- cce_msg.sv
// Message stage: pending-port arbitration, outbound command forming, data forwarding
`timescale 1ns/1ps
`default_nettype none

`include "cce_params.svh"

module cce_msg
  import cce_pkg::*;
  (
    input  cce_cce_id_t    cce_id_i

  , input  logic           dec_v_i
  , input  cce_decoded_s   dec_i
  , output logic           dec_done_o

    // MSHR fields
  , input  cce_addr_t      req_addr_i
  , input  cce_addr_t      lru_addr_i
  , input  cce_lce_id_t    req_lce_i
  , input  cce_way_t       req_way_i
  , input  cce_way_t       lru_way_i
  , input  logic           rd_not_wr_i
  , input  logic           uncached_i
  , input  cce_coh_state_t next_state_i
  , input  cce_nc_data_t   nc_data_i

    // Memory write acknowledgement
  , input  cce_addr_t      mem_resp_addr_i
  , input  logic           mem_resp_v_i
  , output logic           mem_resp_yumi_o

    // Memory data response in, LCE data command out
  , input  cce_block_t     mem_data_resp_i
  , input  cce_addr_t      mem_data_resp_addr_i
  , input  cce_lce_id_t    mem_data_resp_lce_i
  , input  cce_way_t       mem_data_resp_way_i
  , input  logic           mem_data_resp_uc_i
  , input  logic           mem_data_resp_v_i
  , output logic           mem_data_resp_yumi_o

  , output cce_block_t     lce_data_cmd_data_o
  , output cce_lce_id_t    lce_data_cmd_dst_o
  , output cce_way_t       lce_data_cmd_way_o
  , output cce_data_cmd_e  lce_data_cmd_type_o
  , output logic           lce_data_cmd_v_o
  , input  logic           lce_data_cmd_ready_i

    // Pending table
  , output cce_wg_t        pend_rd_wg_o
  , input  logic           pend_rd_bit_i
  , output logic           pend_w_v_o
  , output cce_wg_t        pend_w_wg_o
  , output logic           pend_w_bit_o

    // Output registers
  , output logic           mem_in_v_o
  , output cce_mem_cmd_s   mem_in_o
  , input  logic           mem_in_ready_i
  , output logic           lce_in_v_o
  , output cce_lce_cmd_s   lce_in_o
  , input  logic           lce_in_ready_i
  );

  cce_addr_t mem_addr;
  logic      data_fwd;
  logic      port_free;
  logic      mem_go;
  logic      lce_go;
  logic      nop_go;

  // Data response forwarding owns the pending write port when it happens
  assign data_fwd             = mem_data_resp_v_i & lce_data_cmd_ready_i;
  assign lce_data_cmd_v_o     = mem_data_resp_v_i;
  assign mem_data_resp_yumi_o = data_fwd;
  assign mem_resp_yumi_o      = mem_resp_v_i & ~data_fwd;

  assign lce_data_cmd_data_o = mem_data_resp_i;
  assign lce_data_cmd_dst_o  = mem_data_resp_lce_i;
  assign lce_data_cmd_way_o  = mem_data_resp_uc_i ? '0 : mem_data_resp_way_i;
  assign lce_data_cmd_type_o = mem_data_resp_uc_i ? e_data_cmd_nc : e_data_cmd_cce;

  // Instruction goes last and retries while the port is taken
  assign mem_addr     = dec_i.mem_addr_lru ? lru_addr_i : req_addr_i;
  assign pend_rd_wg_o = mem_addr[`CCE_WG_HIGH-1 -: `CCE_LG_WAY_GROUPS];
  assign port_free    = ~data_fwd & ~mem_resp_yumi_o;

  assign mem_go = dec_v_i & dec_i.mem_cmd_v & port_free & ~pend_rd_bit_i & mem_in_ready_i;
  assign lce_go = dec_v_i & dec_i.lce_cmd_v & port_free & lce_in_ready_i;
  assign nop_go = dec_v_i & ~dec_i.mem_cmd_v & ~dec_i.lce_cmd_v & port_free;

  assign dec_done_o = mem_go | lce_go | nop_go;
  assign mem_in_v_o = mem_go;
  assign lce_in_v_o = lce_go;

  // Pending write port, priority data forward, then ack, then command
  always_comb begin
    pend_w_v_o   = 1'b0;
    pend_w_wg_o  = '0;
    pend_w_bit_o = 1'b0;
    if (data_fwd) begin
      pend_w_v_o  = 1'b1;
      pend_w_wg_o = mem_data_resp_addr_i[`CCE_WG_HIGH-1 -: `CCE_LG_WAY_GROUPS];
    end else if (mem_resp_yumi_o) begin
      pend_w_v_o  = 1'b1;
      pend_w_wg_o = mem_resp_addr_i[`CCE_WG_HIGH-1 -: `CCE_LG_WAY_GROUPS];
    end else if (mem_go) begin
      pend_w_v_o   = 1'b1;
      pend_w_wg_o  = pend_rd_wg_o;
      pend_w_bit_o = 1'b1;
    end
  end

  always_comb begin
    mem_in_o          = '0;
    mem_in_o.msg_type = rd_not_wr_i ? e_mem_rd : e_mem_wr;
    mem_in_o.addr     = mem_addr;
    mem_in_o.lce      = req_lce_i;
    mem_in_o.way      = lru_way_i;
    mem_in_o.uncached = uncached_i;
    // Only an uncached store carries data from the instruction side
    if (!rd_not_wr_i && uncached_i) begin
      mem_in_o.data = cce_block_t'(nc_data_i);
    end
  end

  always_comb begin
    lce_in_o          = '0;
    lce_in_o.src      = cce_id_i;
    lce_in_o.msg_type = dec_i.cmd;
    case (dec_i.lce_sel)
      e_lce_sel_req:  lce_in_o.dst = req_lce_i;
      e_lce_sel_inst: lce_in_o.dst = dec_i.lce;
      default:        lce_in_o.dst = '0;
    endcase
    // Sets are striped across CCEs, so set index = set * num_cce + cce_id
    case (dec_i.addr_sel)
      e_addr_sel_set: begin
        lce_in_o.addr = ((cce_addr_t'(dec_i.set) << `CCE_LG_NUM_CCE) + cce_addr_t'(cce_id_i))
                        << `CCE_LG_BLOCK_BYTES;
      end
      e_addr_sel_req: lce_in_o.addr = req_addr_i;
      e_addr_sel_lru: lce_in_o.addr = lru_addr_i;
      default:        lce_in_o.addr = '0;
    endcase
    case (dec_i.way_sel)
      e_way_sel_req: lce_in_o.way = req_way_i;
      e_way_sel_lru: lce_in_o.way = lru_way_i;
      default:       lce_in_o.way = '0;
    endcase
    if (dec_i.cmd == e_cmd_set_tag) begin
      lce_in_o.state = next_state_i;
    end
    // Transfer sends the victim block to the requester's LRU way
    if (dec_i.cmd == e_cmd_transfer) begin
      lce_in_o.target     = req_lce_i;
      lce_in_o.target_way = lru_way_i;
    end
  end

endmodule

`default_nettype wire

//--- cce_out_reg.sv
// One-entry output register with valid/ready on both sides, generic payload
`timescale 1ns/1ps
`default_nettype none

module cce_out_reg
  #(parameter type payload_t = logic)
  (
    input  logic     clk_i
  , input  logic     rst_i

  , input  logic     in_v_i
  , input  payload_t in_i
  , output logic     in_ready_o

  , output logic     out_v_o
  , output payload_t out_o
  , input  logic     out_ready_i
  );

  logic     full_q;
  payload_t data_q;

  // Room when empty or when the held entry leaves this cycle
  assign in_ready_o = ~full_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_v_i && in_ready_o) begin
      data_q <= in_i;
    end
  end

  assign out_v_o = full_q;
  assign out_o   = data_q;

endmodule

`default_nettype wire

//--- cce_top.sv
// Top level: decode stage, message stage, pending table and two output registers
`timescale 1ns/1ps
`default_nettype none

module cce_top
  import cce_pkg::*;
  (
    input  logic           clk_i
  , input  logic           rst_i
  , input  cce_cce_id_t    cce_id_i

  , input  cce_inst_s      inst_i
  , input  logic           inst_v_i
  , output logic           inst_yumi_o

  , input  cce_addr_t      req_addr_i
  , input  cce_addr_t      lru_addr_i
  , input  cce_lce_id_t    req_lce_i
  , input  cce_way_t       req_way_i
  , input  cce_way_t       lru_way_i
  , input  logic           rd_not_wr_i
  , input  logic           uncached_i
  , input  cce_coh_state_t next_state_i
  , input  cce_nc_data_t   nc_data_i

  , input  cce_addr_t      mem_resp_addr_i
  , input  logic           mem_resp_v_i
  , output logic           mem_resp_yumi_o

  , input  cce_block_t     mem_data_resp_i
  , input  cce_addr_t      mem_data_resp_addr_i
  , input  cce_lce_id_t    mem_data_resp_lce_i
  , input  cce_way_t       mem_data_resp_way_i
  , input  logic           mem_data_resp_uc_i
  , input  logic           mem_data_resp_v_i
  , output logic           mem_data_resp_yumi_o

  , output cce_block_t     lce_data_cmd_data_o
  , output cce_lce_id_t    lce_data_cmd_dst_o
  , output cce_way_t       lce_data_cmd_way_o
  , output cce_data_cmd_e  lce_data_cmd_type_o
  , output logic           lce_data_cmd_v_o
  , input  logic           lce_data_cmd_ready_i

  , output cce_mem_cmd_s   mem_cmd_o
  , output logic           mem_cmd_v_o
  , input  logic           mem_cmd_ready_i

  , output cce_lce_cmd_s   lce_cmd_o
  , output logic           lce_cmd_v_o
  , input  logic           lce_cmd_ready_i
  );

  logic         dec_v;
  cce_decoded_s dec;
  logic         dec_done;

  cce_wg_t      pend_rd_wg;
  logic         pend_rd_bit;
  logic         pend_w_v;
  cce_wg_t      pend_w_wg;
  logic         pend_w_bit;

  logic         mem_in_v;
  cce_mem_cmd_s mem_in;
  logic         mem_in_ready;
  logic         lce_in_v;
  cce_lce_cmd_s lce_in;
  logic         lce_in_ready;

  cce_inst_decode u_decode (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .inst_i      (inst_i),
    .inst_v_i    (inst_v_i),
    .inst_yumi_o (inst_yumi_o),
    .dec_v_o     (dec_v),
    .dec_o       (dec),
    .dec_done_i  (dec_done)
  );

  cce_msg u_msg (
    .cce_id_i             (cce_id_i),
    .dec_v_i              (dec_v),
    .dec_i                (dec),
    .dec_done_o           (dec_done),
    .req_addr_i           (req_addr_i),
    .lru_addr_i           (lru_addr_i),
    .req_lce_i            (req_lce_i),
    .req_way_i            (req_way_i),
    .lru_way_i            (lru_way_i),
    .rd_not_wr_i          (rd_not_wr_i),
    .uncached_i           (uncached_i),
    .next_state_i         (next_state_i),
    .nc_data_i            (nc_data_i),
    .mem_resp_addr_i      (mem_resp_addr_i),
    .mem_resp_v_i         (mem_resp_v_i),
    .mem_resp_yumi_o      (mem_resp_yumi_o),
    .mem_data_resp_i      (mem_data_resp_i),
    .mem_data_resp_addr_i (mem_data_resp_addr_i),
    .mem_data_resp_lce_i  (mem_data_resp_lce_i),
    .mem_data_resp_way_i  (mem_data_resp_way_i),
    .mem_data_resp_uc_i   (mem_data_resp_uc_i),
    .mem_data_resp_v_i    (mem_data_resp_v_i),
    .mem_data_resp_yumi_o (mem_data_resp_yumi_o),
    .lce_data_cmd_data_o  (lce_data_cmd_data_o),
    .lce_data_cmd_dst_o   (lce_data_cmd_dst_o),
    .lce_data_cmd_way_o   (lce_data_cmd_way_o),
    .lce_data_cmd_type_o  (lce_data_cmd_type_o),
    .lce_data_cmd_v_o     (lce_data_cmd_v_o),
    .lce_data_cmd_ready_i (lce_data_cmd_ready_i),
    .pend_rd_wg_o         (pend_rd_wg),
    .pend_rd_bit_i        (pend_rd_bit),
    .pend_w_v_o           (pend_w_v),
    .pend_w_wg_o          (pend_w_wg),
    .pend_w_bit_o         (pend_w_bit),
    .mem_in_v_o           (mem_in_v),
    .mem_in_o             (mem_in),
    .mem_in_ready_i       (mem_in_ready),
    .lce_in_v_o           (lce_in_v),
    .lce_in_o             (lce_in),
    .lce_in_ready_i       (lce_in_ready)
  );

  cce_pending_bits u_pending (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .rd_wg_i  (pend_rd_wg),
    .rd_bit_o (pend_rd_bit),
    .w_v_i    (pend_w_v),
    .w_wg_i   (pend_w_wg),
    .w_bit_i  (pend_w_bit)
  );

  cce_out_reg #(.payload_t(cce_mem_cmd_s)) u_mem_out (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_v_i      (mem_in_v),
    .in_i        (mem_in),
    .in_ready_o  (mem_in_ready),
    .out_v_o     (mem_cmd_v_o),
    .out_o       (mem_cmd_o),
    .out_ready_i (mem_cmd_ready_i)
  );

  cce_out_reg #(.payload_t(cce_lce_cmd_s)) u_lce_out (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_v_i      (lce_in_v),
    .in_i        (lce_in),
    .in_ready_o  (lce_in_ready),
    .out_v_o     (lce_cmd_v_o),
    .out_o       (lce_cmd_o),
    .out_ready_i (lce_cmd_ready_i)
  );

endmodule

`default_nettype wire

//--- cce_assertions.sv
// Bound checker with expected command queues, pending-bit mirror and concurrent assertions
`timescale 1ns/1ps
`default_nettype none

`include "cce_params.svh"

module cce_assertions
  import cce_pkg::*;
  (
    input  logic           clk_i
  , input  logic           rst_i
  , input  cce_cce_id_t    cce_id_i
  , input  cce_inst_s      inst_i
  , input  logic           inst_v_i
  , input  logic           inst_yumi_o
  , input  cce_addr_t      req_addr_i
  , input  cce_addr_t      lru_addr_i
  , input  cce_lce_id_t    req_lce_i
  , input  cce_way_t       req_way_i
  , input  cce_way_t       lru_way_i
  , input  logic           rd_not_wr_i
  , input  logic           uncached_i
  , input  cce_coh_state_t next_state_i
  , input  cce_nc_data_t   nc_data_i
  , input  cce_addr_t      mem_resp_addr_i
  , input  logic           mem_resp_v_i
  , input  logic           mem_resp_yumi_o
  , input  cce_block_t     mem_data_resp_i
  , input  cce_addr_t      mem_data_resp_addr_i
  , input  cce_lce_id_t    mem_data_resp_lce_i
  , input  cce_way_t       mem_data_resp_way_i
  , input  logic           mem_data_resp_uc_i
  , input  logic           mem_data_resp_v_i
  , input  logic           mem_data_resp_yumi_o
  , input  cce_block_t     lce_data_cmd_data_o
  , input  cce_lce_id_t    lce_data_cmd_dst_o
  , input  cce_way_t       lce_data_cmd_way_o
  , input  cce_data_cmd_e  lce_data_cmd_type_o
  , input  logic           lce_data_cmd_v_o
  , input  logic           lce_data_cmd_ready_i
  , input  cce_mem_cmd_s   mem_cmd_o
  , input  logic           mem_cmd_v_o
  , input  logic           mem_cmd_ready_i
  , input  cce_lce_cmd_s   lce_cmd_o
  , input  logic           lce_cmd_v_o
  , input  logic           lce_cmd_ready_i
  );

  logic         failed = 1'b0;
  int           exp_left;
  int           mem_cnt;
  int           lce_cnt;
  cce_mem_cmd_s mem_q[$];
  cce_lce_cmd_s lce_q[$];
  cce_mem_cmd_s exp_mem;
  cce_lce_cmd_s exp_lce;
  cce_mem_cmd_s mem_head;
  cce_lce_cmd_s lce_head;
  logic [(1 << `CCE_LG_WAY_GROUPS)-1:0] pend_q;
  logic         mem_held_q;
  logic         mem_new;
  cce_wg_t      mem_wg;

  // Expected commands from the raw instruction and the MSHR fields
  always_comb begin
    exp_mem          = '0;
    exp_mem.msg_type = rd_not_wr_i ? e_mem_rd : e_mem_wr;
    exp_mem.addr     = (inst_i.cmd == e_cmd_writeback) ? lru_addr_i : req_addr_i;
    exp_mem.lce      = req_lce_i;
    exp_mem.way      = lru_way_i;
    exp_mem.uncached = uncached_i;
    if (!rd_not_wr_i && uncached_i) begin
      exp_mem.data = {{(`CCE_BLOCK_WIDTH-`CCE_NC_DATA_WIDTH){1'b0}}, nc_data_i};
    end
    exp_lce          = '0;
    exp_lce.src      = cce_id_i;
    exp_lce.msg_type = inst_i.cmd;
    exp_lce.dst      = (inst_i.lce_sel == e_lce_sel_req)  ? req_lce_i :
                       (inst_i.lce_sel == e_lce_sel_inst) ? inst_i.lce : '0;
    exp_lce.way      = (inst_i.way_sel == e_way_sel_req) ? req_way_i :
                       (inst_i.way_sel == e_way_sel_lru) ? lru_way_i : '0;
    case (inst_i.addr_sel)
      // Set index, then CCE id, then block offset
      e_addr_sel_set: exp_lce.addr = cce_addr_t'({inst_i.set, cce_id_i,
                                                  {`CCE_LG_BLOCK_BYTES{1'b0}}});
      e_addr_sel_req: exp_lce.addr = req_addr_i;
      e_addr_sel_lru: exp_lce.addr = lru_addr_i;
      default:        exp_lce.addr = '0;
    endcase
    if (inst_i.cmd == e_cmd_set_tag) begin
      exp_lce.state = next_state_i;
    end
    if (inst_i.cmd == e_cmd_transfer) begin
      exp_lce.target     = req_lce_i;
      exp_lce.target_way = lru_way_i;
    end
  end

  assign mem_wg  = mem_cmd_o.addr[`CCE_WG_HIGH-1 -: `CCE_LG_WAY_GROUPS];
  // A valid that was not held over from the last cycle is a new entry
  assign mem_new = mem_cmd_v_o & ~mem_held_q;

  always @(posedge clk_i) begin
    if (rst_i) begin
      mem_q.delete();
      lce_q.delete();
      mem_cnt    <= 0;
      lce_cnt    <= 0;
      exp_left   <= 0;
      mem_head   <= '0;
      lce_head   <= '0;
      pend_q     <= '0;
      mem_held_q <= 1'b0;
    end else begin
      if (mem_cmd_v_o && mem_cmd_ready_i) begin
        void'(mem_q.pop_front());
      end
      if (lce_cmd_v_o && lce_cmd_ready_i) begin
        void'(lce_q.pop_front());
      end
      if (inst_v_i && inst_yumi_o && inst_i.op == e_op_mem_cmd) begin
        mem_q.push_back(exp_mem);
      end
      if (inst_v_i && inst_yumi_o && inst_i.op == e_op_lce_cmd) begin
        lce_q.push_back(exp_lce);
      end
      // Queue state as seen from the next cycle on
      mem_cnt    <= mem_q.size();
      lce_cnt    <= lce_q.size();
      exp_left   <= mem_q.size() + lce_q.size();
      mem_head   <= (mem_q.size() != 0) ? mem_q[0] : '0;
      lce_head   <= (lce_q.size() != 0) ? lce_q[0] : '0;
      mem_held_q <= mem_cmd_v_o & ~mem_cmd_ready_i;
      if (mem_resp_yumi_o) begin
        pend_q[mem_resp_addr_i[`CCE_WG_HIGH-1 -: `CCE_LG_WAY_GROUPS]] <= 1'b0;
      end
      if (mem_data_resp_yumi_o) begin
        pend_q[mem_data_resp_addr_i[`CCE_WG_HIGH-1 -: `CCE_LG_WAY_GROUPS]] <= 1'b0;
      end
      if (mem_new) begin
        pend_q[mem_wg] <= 1'b1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i) rst_i |=> !mem_cmd_v_o && !lce_cmd_v_o)
    else begin $error("Output valid high right after reset"); failed = 1'b1; end

  a_inst_yumi: assert property (@(posedge clk_i) !inst_v_i |-> !inst_yumi_o)
    else begin $error("inst_yumi_o high without inst_v_i"); failed = 1'b1; end

  a_resp_yumi: assert property (@(posedge clk_i) !mem_resp_v_i |-> !mem_resp_yumi_o)
    else begin $error("mem_resp_yumi_o high without mem_resp_v_i"); failed = 1'b1; end

  a_mem_cmd: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_cmd_v_o |-> mem_cnt != 0 && mem_cmd_o == mem_head)
    else begin
      $error("ERROR mem_cmd_o=%h expected %h", mem_cmd_o, mem_head);
      failed = 1'b1;
    end

  a_lce_cmd: assert property (@(posedge clk_i) disable iff (rst_i)
    lce_cmd_v_o |-> lce_cnt != 0 && lce_cmd_o == lce_head)
    else begin
      $error("ERROR lce_cmd_o=%h expected %h", lce_cmd_o, lce_head);
      failed = 1'b1;
    end

  a_mem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_o))
    else begin $error("mem_cmd_o dropped or changed before ready"); failed = 1'b1; end

  a_lce_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o && $stable(lce_cmd_o))
    else begin $error("lce_cmd_o dropped or changed before ready"); failed = 1'b1; end

  a_data_v: assert property (@(posedge clk_i) disable iff (rst_i)
    lce_data_cmd_v_o == mem_data_resp_v_i)
    else begin
      $error("ERROR lce_data_cmd_v_o=%h expected %h", lce_data_cmd_v_o, mem_data_resp_v_i);
      failed = 1'b1;
    end

  a_data_fields: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_data_resp_v_i |-> lce_data_cmd_data_o == mem_data_resp_i
      && lce_data_cmd_dst_o == mem_data_resp_lce_i
      && lce_data_cmd_way_o == (mem_data_resp_uc_i ? cce_way_t'(0) : mem_data_resp_way_i)
      && lce_data_cmd_type_o == (mem_data_resp_uc_i ? e_data_cmd_nc : e_data_cmd_cce))
    else begin
      $error("ERROR lce_data_cmd data=%h dst=%h way=%h type=%h",
             lce_data_cmd_data_o, lce_data_cmd_dst_o, lce_data_cmd_way_o,
             lce_data_cmd_type_o);
      failed = 1'b1;
    end

  a_data_yumi: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_data_resp_yumi_o == (mem_data_resp_v_i && lce_data_cmd_ready_i))
    else begin
      $error("ERROR mem_data_resp_yumi_o=%h", mem_data_resp_yumi_o);
      failed = 1'b1;
    end

  a_one_yumi: assert property (@(posedge clk_i) !(mem_resp_yumi_o && mem_data_resp_yumi_o))
    else begin $error("Both memory responses consumed in one cycle"); failed = 1'b1; end

  a_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_new |-> !pend_q[mem_wg])
    else begin
      $error("ERROR mem_cmd_o addr=%h issued while way group %h is pending",
             mem_cmd_o.addr, mem_wg);
      failed = 1'b1;
    end

endmodule

bind cce_top cce_assertions u_chk (.*);

`default_nettype wire

//--- tb_cce.sv
// Testbench top with clock, reset, random stimulus, memory responder and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_cce
  import cce_pkg::*;
  ;

  localparam int num_inst   = 120;
  localparam int max_cycles = 4000;

  logic           clk_i = 1'b0;
  logic           rst_i;
  cce_cce_id_t    cce_id_i;
  cce_inst_s      inst_i;
  logic           inst_v_i;
  logic           inst_yumi_o;
  cce_addr_t      req_addr_i;
  cce_addr_t      lru_addr_i;
  cce_lce_id_t    req_lce_i;
  cce_way_t       req_way_i;
  cce_way_t       lru_way_i;
  logic           rd_not_wr_i;
  logic           uncached_i;
  cce_coh_state_t next_state_i;
  cce_nc_data_t   nc_data_i;
  cce_addr_t      mem_resp_addr_i;
  logic           mem_resp_v_i;
  logic           mem_resp_yumi_o;
  cce_block_t     mem_data_resp_i;
  cce_addr_t      mem_data_resp_addr_i;
  cce_lce_id_t    mem_data_resp_lce_i;
  cce_way_t       mem_data_resp_way_i;
  logic           mem_data_resp_uc_i;
  logic           mem_data_resp_v_i;
  logic           mem_data_resp_yumi_o;
  cce_block_t     lce_data_cmd_data_o;
  cce_lce_id_t    lce_data_cmd_dst_o;
  cce_way_t       lce_data_cmd_way_o;
  cce_data_cmd_e  lce_data_cmd_type_o;
  logic           lce_data_cmd_v_o;
  logic           lce_data_cmd_ready_i;
  cce_mem_cmd_s   mem_cmd_o;
  logic           mem_cmd_v_o;
  logic           mem_cmd_ready_i;
  cce_lce_cmd_s   lce_cmd_o;
  logic           lce_cmd_v_o;
  logic           lce_cmd_ready_i;

  integer    seed;
  int        cycles;
  int        mem_fires;
  int        lce_fires;
  logic      resp_busy;
  cce_addr_t resp_q[$];

  cce_top i_cce_top (.*);

  always #20 clk_i = ~clk_i;

  // Random back-pressure on every outbound channel
  always @(negedge clk_i) begin
    logic [31:0] r;
    if (!rst_i) begin
      r = $random(seed);
      mem_cmd_ready_i      = r[1:0] != 2'd0;
      lce_cmd_ready_i      = r[3:2] != 2'd0;
      lce_data_cmd_ready_i = r[5:4] != 2'd0;
    end
  end

  // Count accepted commands, and queue each memory address for a response
  always @(posedge clk_i) begin
    if (!rst_i && mem_cmd_v_o && mem_cmd_ready_i) begin
      mem_fires = mem_fires + 1;
      resp_q.push_back(mem_cmd_o.addr);
    end
    if (!rst_i && lce_cmd_v_o && lce_cmd_ready_i) begin
      lce_fires = lce_fires + 1;
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (i_cce_top.u_chk.failed) begin
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first failed assertion");
    end else if (cycles >= max_cycles) begin
      $display("SOME TESTS FAILED");
      $fatal(1, "Timeout after %0d cycles", cycles);
    end
  end

  // Memory model answers commands later with an ack, a data response or both at once
  initial begin
    logic [31:0] r;
    logic        data_wait;
    logic        ack_wait;
    resp_busy = 1'b0;
    forever begin
      @(negedge clk_i);
      r = $random(seed);
      if (!rst_i && resp_q.size() != 0 && r[1:0] == 2'd0) begin
        resp_busy = 1'b1;
        data_wait = r[2];
        // Sometimes a second queued address is acked while data is offered
        ack_wait  = !r[2] || (r[3] && resp_q.size() > 1);
        if (data_wait) begin
          mem_data_resp_addr_i = resp_q.pop_front();
          mem_data_resp_i      = {$random(seed), $random(seed)};
          mem_data_resp_lce_i  = r[9:8];
          mem_data_resp_way_i  = r[11:10];
          mem_data_resp_uc_i   = r[12];
          mem_data_resp_v_i    = 1'b1;
        end
        if (ack_wait) begin
          mem_resp_addr_i = resp_q.pop_front();
          mem_resp_v_i    = 1'b1;
        end
        while (data_wait || ack_wait) begin
          @(posedge clk_i);
          if (mem_data_resp_yumi_o) begin
            data_wait = 1'b0;
          end
          if (mem_resp_yumi_o) begin
            ack_wait = 1'b0;
          end
          @(negedge clk_i);
          if (!data_wait) begin
            mem_data_resp_v_i = 1'b0;
          end
          if (!ack_wait) begin
            mem_resp_v_i = 1'b0;
          end
        end
        resp_busy = 1'b0;
      end
    end
  end

  // Drives one instruction with fresh MSHR fields and holds them until its command leaves
  task automatic issue_inst();
    logic [31:0] r;
    cce_inst_s   inst;
    int          n_mem;
    int          n_lce;
    @(negedge clk_i);
    r = $random(seed);
    req_addr_i = r[15:0];
    lru_addr_i = r[31:16];
    r = $random(seed);
    req_lce_i    = r[1:0];
    req_way_i    = r[3:2];
    lru_way_i    = r[5:4];
    rd_not_wr_i  = r[6];
    uncached_i   = r[7];
    next_state_i = r[10:8];
    nc_data_i    = r[31:16];
    r = $random(seed);
    inst = cce_inst_s'(r[15:0]);
    // Mostly real commands and a few no-ops
    inst.op = (r[18:16] == 3'd0) ? cce_op_e'(2'd2) : cce_op_e'({1'b0, r[19]});
    n_mem    = mem_fires;
    n_lce    = lce_fires;
    inst_i   = inst;
    inst_v_i = 1'b1;
    do @(posedge clk_i); while (!inst_yumi_o);
    @(negedge clk_i);
    inst_v_i = 1'b0;
    if (inst.op == e_op_mem_cmd) begin
      while (mem_fires == n_mem) @(posedge clk_i);
    end else if (inst.op == e_op_lce_cmd) begin
      while (lce_fires == n_lce) @(posedge clk_i);
    end
  endtask

  initial begin
    seed                 = 32'he9cc;
    cycles               = 0;
    mem_fires            = 0;
    lce_fires            = 0;
    rst_i                = 1'b1;
    cce_id_i             = 1'b1;
    inst_i               = '0;
    inst_v_i             = 1'b0;
    req_addr_i           = '0;
    lru_addr_i           = '0;
    req_lce_i            = '0;
    req_way_i            = '0;
    lru_way_i            = '0;
    rd_not_wr_i          = 1'b0;
    uncached_i           = 1'b0;
    next_state_i         = '0;
    nc_data_i            = '0;
    mem_resp_addr_i      = '0;
    mem_resp_v_i         = 1'b0;
    mem_data_resp_i      = '0;
    mem_data_resp_addr_i = '0;
    mem_data_resp_lce_i  = '0;
    mem_data_resp_way_i  = '0;
    mem_data_resp_uc_i   = 1'b0;
    mem_data_resp_v_i    = 1'b0;
    lce_data_cmd_ready_i = 1'b0;
    mem_cmd_ready_i      = 1'b0;
    lce_cmd_ready_i      = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int i = 0; i < num_inst; i++) begin
      issue_inst();
    end
    // Drain the memory model and both output registers
    while (resp_q.size() != 0 || resp_busy || mem_cmd_v_o || lce_cmd_v_o) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    if (i_cce_top.u_chk.failed || i_cce_top.u_chk.exp_left != 0) begin
      $display("SOME TESTS FAILED");
      $fatal(1, "Checker failed or %0d expected commands never left",
             i_cce_top.u_chk.exp_left);
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
cce_pkg.sv
cce_inst_decode.sv
cce_pending_bits.sv
cce_msg.sv
cce_out_reg.sv
cce_top.sv
cce_assertions.sv
tb_cce.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_cce -f sources.f -o vsim_cce
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/vsim_cce)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation returned a failing status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^ALL TESTS PASSED$'; then
  exit 0
fi
exit 1
